// File: design/heading_integrator.sv
`timescale 1ns/1ns
`default_nettype none

`include "runner_params.svh"

module heading_integrator (
  input wire                           clk,
  input wire                           rst_n,
  input wire runner_types_pkg::omega_t omega_lft,   // fresh with omega_vld
  input wire runner_types_pkg::omega_t omega_rght,
  input wire                           omega_vld,
  input wire                           enable,
  input wire                           clear,
  motion_if.src                        motion       // aligned model state
);

  import runner_types_pkg::*;

  localparam logic signed [15:0] GAIN = `RUNNER_HEADING_GAIN;  // positive

  logic signed [15:0] rate;         // platform angular rate
  logic signed [31:0] prod;
  heading_t           heading_nxt;

  // wheel difference plus a quarter of each wheel, 16 bit wrap
  assign rate        = omega_rght - omega_lft + (omega_rght >>> 2) - (omega_lft >>> 2);
  assign prod        = rate * GAIN;
  assign heading_nxt = motion.heading + $signed(prod[31:16]);  // wraps at 20 bits

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      motion.omega_lft  <= '0;
      motion.omega_rght <= '0;
      motion.heading    <= '0;  // north
      motion.upd        <= 1'b0;
    end else begin
      motion.upd <= omega_vld && enable && !clear;
      if (clear) begin
        motion.omega_lft  <= '0;
        motion.omega_rght <= '0;
        motion.heading    <= '0;
      end else if (omega_vld && enable) begin
        motion.omega_lft  <= omega_lft;   // carried so regs see one snapshot
        motion.omega_rght <= omega_rght;
        motion.heading    <= heading_nxt;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/pwm_duty_capture.sv
`timescale 1ns/1ns
`default_nettype none

`include "runner_params.svh"

module pwm_duty_capture (
  input wire  clk,
  input wire  rst_n,
  input wire  lft_pwm1,   // left motor pins
  input wire  lft_pwm2,
  input wire  rght_pwm1,  // right motor pins
  input wire  rght_pwm2,
  duty_if.src duty        // held duties plus window strobe
);

  import runner_types_pkg::*;

  localparam int NCH = 4;  // lft1, lft2, rght1, rght2

  logic [`RUNNER_PWM_CNT_W-1:0] per_cnt;       // shared window counter
  logic [`RUNNER_PWM_CNT_W-1:0] hi_cnt [NCH];  // high cycles so far
  duty_t                        duty_q [NCH];  // last complete window
  logic [NCH-1:0]               pwm_in;
  logic                         win_end;

  assign pwm_in  = {rght_pwm2, rght_pwm1, lft_pwm2, lft_pwm1};  // index = channel
  assign win_end = &per_cnt;                                     // last cycle of window

  ////////////////////
  // window timing
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      per_cnt <= '0;
    end else begin
      per_cnt <= per_cnt + 1'b1;  // wraps every 4096 cycles
    end
  end

  ////////////////////
  // high time per pin
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NCH; i++) begin
        hi_cnt[i] <= '0;
        duty_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NCH; i++) begin
        if (win_end) begin
          duty_q[i] <= hi_cnt[i][`RUNNER_PWM_CNT_W-1:1];  // halve, lsb dropped
          hi_cnt[i] <= '0;                                 // pin level here is lost
        end else if (pwm_in[i]) begin
          hi_cnt[i] <= hi_cnt[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty.vld <= 1'b0;
    end else begin
      duty.vld <= win_end;  // lands with the new duties
    end
  end

  assign duty.lft1  = duty_q[0];
  assign duty.lft2  = duty_q[1];
  assign duty.rght1 = duty_q[2];
  assign duty.rght2 = duty_q[3];

  // downstream stages treat every vld as a fresh window
  a_vld_single: assert property (@(posedge clk) disable iff (!rst_n)
    duty.vld |=> !duty.vld);

endmodule

`default_nettype wire

// File: design/runner_apb_pkg.sv
`default_nettype none

`include "runner_params.svh"

package runner_apb_pkg;

  ////////////////////
  // register map
  ////////////////////
  typedef enum logic [`RUNNER_APB_AW-1:0] {
    CTRL       = 8'h00,  // enable, clear strobe
    OMEGA_LFT  = 8'h04,  // left wheel velocity, ro
    OMEGA_RGHT = 8'h08,  // right wheel velocity, ro
    HEADING    = 8'h0C,  // platform heading, ro
    DUTY_LFT   = 8'h10,  // lft2 in 26:16, lft1 in 10:0
    DUTY_RGHT  = 8'h14,  // rght2 in 26:16, rght1 in 10:0
    UPD_CNT    = 8'h18   // model updates since reset or clear
  } reg_addr_e;

  // control word, clear self-clears after one cycle
  typedef struct packed {
    logic clear;   // bit 1
    logic enable;  // bit 0
  } ctrl_t;

endpackage

`default_nettype wire

// File: design/runner_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "runner_params.svh"

module runner_apb_regs (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire [`RUNNER_APB_AW-1:0]    paddr,
  input  wire                         psel,
  input  wire                         penable,
  input  wire                         pwrite,
  input  wire [31:0]                  pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,     // one wait state
  output logic                        pslverr,
  motion_if.dst                       motion,
  input  wire [2*`RUNNER_DUTY_W-1:0]  duty_lft,   // {lft2, lft1}
  input  wire [2*`RUNNER_DUTY_W-1:0]  duty_rght,  // {rght2, rght1}
  output logic                        enable,
  output logic                        clear
);

  import runner_types_pkg::*;
  import runner_apb_pkg::*;

  ctrl_t       ctrl;
  logic [15:0] upd_cnt;  // model updates
  logic        acc_cyc;  // first access phase cycle
  logic [31:0] rd_data;
  logic        rd_err;
  logic        wr_err;

  // second duty in the upper half word
  function automatic logic [31:0] pack_duty(input duty_t d1, input duty_t d2);
    return (32'(d2) << 16) | 32'(d1);
  endfunction

  assign acc_cyc = psel && penable && !pready;
  assign enable  = ctrl.enable;
  assign clear   = ctrl.clear;
  assign wr_err  = (paddr != CTRL);  // everything else is read only

  ////////////////////
  // read decode
  ////////////////////
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (paddr)
      CTRL:       rd_data = 32'(ctrl.enable);       // clear never reads back
      OMEGA_LFT:  rd_data = 32'(motion.omega_lft);  // sign extended
      OMEGA_RGHT: rd_data = 32'(motion.omega_rght);
      HEADING:    rd_data = 32'(motion.heading);
      DUTY_LFT:   rd_data = pack_duty(duty_lft[`RUNNER_DUTY_W-1:0],
                                      duty_lft[2*`RUNNER_DUTY_W-1:`RUNNER_DUTY_W]);
      DUTY_RGHT:  rd_data = pack_duty(duty_rght[`RUNNER_DUTY_W-1:0],
                                      duty_rght[2*`RUNNER_DUTY_W-1:`RUNNER_DUTY_W]);
      UPD_CNT:    rd_data = 32'(upd_cnt);
      default:    rd_err  = 1'b1;                   // unmapped reads zero
    endcase
  end

  ////////////////////
  // bus handshake
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= acc_cyc;  // high for exactly one cycle
      pslverr <= acc_cyc && (pwrite ? wr_err : rd_err);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prdata <= '0;
    end else if (acc_cyc) begin
      prdata <= pwrite ? '0 : rd_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl <= '{clear: 1'b0, enable: 1'b1};   // model runs out of reset
    end else if (acc_cyc && pwrite && !wr_err) begin
      ctrl <= ctrl_t'(pwdata[1:0]);
    end else begin
      ctrl.clear <= 1'b0;                     // one cycle strobe
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      upd_cnt <= '0;
    end else if (ctrl.clear) begin
      upd_cnt <= '0;
    end else if (motion.upd) begin
      upd_cnt <= upd_cnt + 1'b1;
    end
  end

  a_penable_in_sel: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel);

endmodule

`default_nettype wire

// File: design/runner_ifs.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////
// capture to dynamics
////////////////////
interface duty_if;
  import runner_types_pkg::*;

  duty_t lft1;   // left motor forward leg
  duty_t lft2;   // left motor reverse leg
  duty_t rght1;  // right motor, mirrored
  duty_t rght2;
  logic  vld;    // one cycle strobe per window

  modport src (output lft1, output lft2, output rght1, output rght2, output vld);
  modport dst (input lft1, input lft2, input rght1, input rght2, input vld);

endinterface

////////////////////
// heading to regs
////////////////////
interface motion_if;
  import runner_types_pkg::*;

  omega_t   omega_lft;   // aligned with heading
  omega_t   omega_rght;
  heading_t heading;
  logic     upd;         // all three just refreshed

  modport src (output omega_lft, output omega_rght, output heading, output upd);
  modport dst (input omega_lft, input omega_rght, input heading, input upd);

endinterface

`default_nettype wire

// File: design/runner_params.svh
`ifndef RUNNER_PARAMS_SVH
`define RUNNER_PARAMS_SVH

////////////////////
// pwm measurement
////////////////////
`define RUNNER_PWM_CNT_W    12        // window counter width, 4096 cycle window
`define RUNNER_DUTY_W       11        // high count with its lsb dropped

////////////////////
// wheel and platform physics
////////////////////
`define RUNNER_OMEGA_MAX    32700     // wheel velocity clamp, either sign
`define RUNNER_HEADING_GAIN 16'h1FA0  // platform rate to heading step

////////////////////
// register bus
////////////////////
`define RUNNER_APB_AW       8         // byte address width

`endif

// File: design/runner_physics_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "runner_params.svh"

module runner_physics_top (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       lft_pwm1,   // left motor drive
  input  wire                       lft_pwm2,
  input  wire                       rght_pwm1,  // right motor drive
  input  wire                       rght_pwm2,
  input  wire [`RUNNER_APB_AW-1:0]  paddr,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire [31:0]                pwdata,
  output wire [31:0]                prdata,
  output wire                       pready,
  output wire                       pslverr
);

  import runner_types_pkg::*;

  duty_if   duty_bus ();    // capture -> dynamics
  motion_if motion_bus ();  // heading -> regs

  omega_t omega_lft;        // dynamics -> heading
  omega_t omega_rght;
  logic   omega_vld;
  logic   enable;           // from control register
  logic   clear;

  ////////////////////
  // pipeline
  ////////////////////
  pwm_duty_capture u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .lft_pwm1  (lft_pwm1),
    .lft_pwm2  (lft_pwm2),
    .rght_pwm1 (rght_pwm1),
    .rght_pwm2 (rght_pwm2),
    .duty      (duty_bus.src)
  );

  wheel_dynamics u_dynamics (
    .clk        (clk),
    .rst_n      (rst_n),
    .duty       (duty_bus.dst),
    .enable     (enable),
    .clear      (clear),
    .omega_lft  (omega_lft),
    .omega_rght (omega_rght),
    .omega_vld  (omega_vld)
  );

  heading_integrator u_heading (
    .clk        (clk),
    .rst_n      (rst_n),
    .omega_lft  (omega_lft),
    .omega_rght (omega_rght),
    .omega_vld  (omega_vld),
    .enable     (enable),
    .clear      (clear),
    .motion     (motion_bus.src)
  );

  runner_apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .motion    (motion_bus.dst),
    .duty_lft  ({duty_bus.lft2, duty_bus.lft1}),    // held duties, not re-timed
    .duty_rght ({duty_bus.rght2, duty_bus.rght1}),
    .enable    (enable),
    .clear     (clear)
  );

endmodule

`default_nettype wire

// File: design/runner_types_pkg.sv
`default_nettype none

`include "runner_params.svh"

package runner_types_pkg;

  ////////////////////
  // motor drive
  ////////////////////

  // half the high count of one pwm pin over a window
  typedef logic [`RUNNER_DUTY_W-1:0] duty_t;

  ////////////////////
  // wheel state
  ////////////////////
  typedef logic signed [12:0] alpha_t;  // angular accel, saturates
  typedef logic signed [15:0] omega_t;  // angular velocity, clamped

  ////////////////////
  // platform state
  ////////////////////

  // integrated heading, zero is north, full scale wraps around
  typedef logic signed [19:0] heading_t;

endpackage

`default_nettype wire

// File: design/wheel_dynamics.sv
`timescale 1ns/1ns
`default_nettype none

`include "runner_params.svh"

module wheel_dynamics (
  input  wire                      clk,
  input  wire                      rst_n,
  duty_if.dst                      duty,        // duties from capture
  input  wire                      enable,      // model running
  input  wire                      clear,       // zero both wheels
  output runner_types_pkg::omega_t omega_lft,
  output runner_types_pkg::omega_t omega_rght,
  output logic                     omega_vld    // new velocities
);

  import runner_types_pkg::*;

  localparam logic signed [16:0] ALPHA_HI = 17'sd4095;   // alpha_t range
  localparam logic signed [16:0] ALPHA_LO = -17'sd4096;
  localparam logic signed [17:0] OMEGA_HI = `RUNNER_OMEGA_MAX;
  localparam logic signed [17:0] OMEGA_LO = -`RUNNER_OMEGA_MAX;

  alpha_t alpha_lft;
  alpha_t alpha_rght;
  omega_t omega_lft_nxt;
  omega_t omega_rght_nxt;

  ////////////////////
  // wheel equations
  ////////////////////

  // torque is the duty difference, back emf pulls it down
  function automatic alpha_t calc_alpha(input duty_t d_pos, input duty_t d_neg,
                                        input omega_t om);
    logic signed [16:0] torque;
    logic signed [16:0] om_x;
    logic signed [16:0] acc;
    torque = $signed({6'b0, d_pos}) - $signed({6'b0, d_neg});
    om_x   = om;                                    // sign extend
    acc    = torque - (om_x >>> 4) - (om_x >>> 6);
    if (acc > ALPHA_HI) begin
      return ALPHA_HI[12:0];                        // saturate high
    end else if (acc < ALPHA_LO) begin
      return ALPHA_LO[12:0];                        // saturate low
    end
    return acc[12:0];
  endfunction

  // velocity integrates alpha, single back emf loss
  function automatic omega_t calc_omega(input omega_t om, input alpha_t al);
    logic signed [17:0] om_x;
    logic signed [17:0] al_x;
    logic signed [17:0] sum;
    om_x = om;
    al_x = al;
    sum  = om_x + (al_x >>> 2) - (om_x >>> 6);
    if (sum > OMEGA_HI) begin
      return OMEGA_HI[15:0];
    end else if (sum < OMEGA_LO) begin
      return OMEGA_LO[15:0];
    end
    return sum[15:0];
  endfunction

  assign alpha_lft      = calc_alpha(duty.lft1, duty.lft2, omega_lft);
  assign alpha_rght     = calc_alpha(duty.rght2, duty.rght1, omega_rght);  // mirrored
  assign omega_lft_nxt  = calc_omega(omega_lft, alpha_lft);
  assign omega_rght_nxt = calc_omega(omega_rght, alpha_rght);

  ////////////////////
  // state update
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      omega_lft  <= '0;
      omega_rght <= '0;
      omega_vld  <= 1'b0;
    end else begin
      omega_vld <= duty.vld && enable && !clear;  // clear swallows the strobe
      if (clear) begin
        omega_lft  <= '0;
        omega_rght <= '0;
      end else if (duty.vld && enable) begin
        omega_lft  <= omega_lft_nxt;
        omega_rght <= omega_rght_nxt;
      end
    end
  end

  a_omega_clamp: assert property (@(posedge clk) disable iff (!rst_n)
    (omega_lft >= OMEGA_LO) && (omega_lft <= OMEGA_HI) &&
    (omega_rght >= OMEGA_LO) && (omega_rght <= OMEGA_HI));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the runner physics testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f runner_physics.f \
  --top-module runner_physics_tb \
  -o runner_physics_sim

./obj_dir/runner_physics_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed, log in sim.log"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: runner_physics.f
+incdir+design
design/runner_types_pkg.sv
design/runner_apb_pkg.sv
design/runner_ifs.sv
design/pwm_duty_capture.sv
design/wheel_dynamics.sv
design/heading_integrator.sv
design/runner_apb_regs.sv
design/runner_physics_top.sv
sim/runner_physics_checker.sv
sim/runner_physics_tb.sv

// File: sim/runner_physics_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "runner_params.svh"

module runner_physics_checker (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      lft_pwm1,   // same pins the dut sees
  input  wire                      lft_pwm2,
  input  wire                      rght_pwm1,
  input  wire                      rght_pwm2,
  input  wire [`RUNNER_APB_AW-1:0] paddr,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire [31:0]               pwdata,
  input  wire [31:0]               prdata,
  input  wire                      pready,
  input  wire                      pslverr,
  output int                       data_errs,  // wrong read data
  output int                       bus_errs,   // handshake or pslverr
  output int                       reads       // reads compared
);

  import runner_apb_pkg::*;

  localparam int WIN_LAST = (1 << `RUNNER_PWM_CNT_W) - 1;

  int         win_cnt;     // window position, from reset release
  int         hi_cnt [4];  // lft1, lft2, rght1, rght2
  int         duty [4];    // last complete window, halved
  int         om_l;
  int         om_r;
  int         head;        // kept sign extended from 20 bits
  int         upd_cnt;
  logic       en;
  int         acc_len;     // access phase cycles so far
  logic [3:0] pins;

  assign pins = {rght_pwm2, rght_pwm1, lft_pwm2, lft_pwm1};

  ////////////////////
  // reference model
  ////////////////////
  function automatic int clip(input int v, input int lo, input int hi);
    if (v > hi) begin
      return hi;
    end else if (v < lo) begin
      return lo;
    end
    return v;
  endfunction

  // torque less back emf gives alpha, alpha drives omega
  function automatic int step_omega(input int torque, input int om);
    int alpha;
    alpha = clip(torque - (om >>> 4) - (om >>> 6), -4096, 4095);  // alpha_t range
    return clip(om + (alpha >>> 2) - (om >>> 6), -`RUNNER_OMEGA_MAX, `RUNNER_OMEGA_MAX);
  endfunction

  function automatic int step_heading(input int hd, input int ol, input int orr);
    logic signed [15:0] rate;
    logic signed [19:0] h;
    int                 gain;
    int                 step;
    gain = `RUNNER_HEADING_GAIN;
    rate = 16'(orr - ol + (orr >>> 2) - (ol >>> 2));  // 16 bit wrap
    step = (int'(rate) * gain) >>> 16;
    h    = 20'(hd + step);                             // heading wraps
    return int'(h);
  endfunction

  function automatic logic is_mapped(input logic [`RUNNER_APB_AW-1:0] addr);
    return addr inside {CTRL, OMEGA_LFT, OMEGA_RGHT, HEADING, DUTY_LFT, DUTY_RGHT, UPD_CNT};
  endfunction

  function automatic logic [31:0] expected_rdata(input logic [`RUNNER_APB_AW-1:0] addr);
    case (addr)
      CTRL:       return {31'b0, en};
      OMEGA_LFT:  return om_l;
      OMEGA_RGHT: return om_r;
      HEADING:    return head;
      DUTY_LFT:   return (duty[1] << 16) | duty[0];
      DUTY_RGHT:  return (duty[3] << 16) | duty[2];
      UPD_CNT:    return upd_cnt;
      default:    return '0;  // unmapped
    endcase
  endfunction

  task automatic end_window();
    for (int i = 0; i < 4; i++) begin
      duty[i]   = hi_cnt[i] >> 1;  // lsb dropped
      hi_cnt[i] = 0;
    end
    if (en) begin
      om_l    = step_omega(duty[0] - duty[1], om_l);
      om_r    = step_omega(duty[3] - duty[2], om_r);  // mirrored motor
      head    = step_heading(head, om_l, om_r);       // uses fresh omegas
      upd_cnt = (upd_cnt + 1) & 16'hFFFF;
    end
  endtask

  task automatic check_access();
    logic [31:0] exp;
    logic        exp_err;
    exp_err = pwrite ? (paddr != CTRL) : !is_mapped(paddr);
    if (acc_len != 2) begin
      bus_errs++;
      $display("error @%0t: access to 0x%02h took %0d cycles, expected 2",
               $time, paddr, acc_len);
    end
    if (pslverr !== exp_err) begin
      bus_errs++;
      $display("error @%0t: pslverr %b at 0x%02h, expected %b", $time, pslverr, paddr, exp_err);
    end
    if (pwrite) begin
      if (!exp_err) begin
        en = pwdata[0];
        if (pwdata[1]) begin  // clear strobe
          om_l    = 0;
          om_r    = 0;
          head    = 0;
          upd_cnt = 0;
        end
      end
    end else begin
      reads++;
      exp = expected_rdata(paddr);
      if (prdata !== exp) begin
        data_errs++;
        $display("error @%0t: read 0x%02h returned 0x%08h, model has 0x%08h",
                 $time, paddr, prdata, exp);
      end
    end
  endtask

  ////////////////////
  // sampling
  ////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_cnt = 0;
      for (int i = 0; i < 4; i++) begin
        hi_cnt[i] = 0;
        duty[i]   = 0;
      end
      om_l      = 0;
      om_r      = 0;
      head      = 0;
      upd_cnt   = 0;
      en        = 1'b1;  // enabled out of reset
      acc_len   = 0;
      data_errs = 0;
      bus_errs  = 0;
      reads     = 0;
    end else begin
      if (win_cnt == WIN_LAST) begin
        end_window();  // pin level on this cycle is not counted
      end else begin
        for (int i = 0; i < 4; i++) begin
          if (pins[i]) begin
            hi_cnt[i]++;
          end
        end
      end
      win_cnt = (win_cnt + 1) & WIN_LAST;
      if (!psel) begin
        acc_len = 0;
      end else if (penable) begin
        acc_len++;
      end
      if (psel && penable && pready) begin
        check_access();
        acc_len = 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/runner_physics_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "runner_params.svh"

module runner_physics_tb;

  import runner_apb_pkg::*;

  localparam int WIN_LEN  = 1 << `RUNNER_PWM_CNT_W;  // cycles per window
  localparam int BUS_WAIT = 16;                       // cycles allowed for pready

  logic                      clk       = 1'b0;
  logic                      rst_n     = 1'b0;
  logic                      lft_pwm1  = 1'b0;
  logic                      lft_pwm2  = 1'b0;
  logic                      rght_pwm1 = 1'b0;
  logic                      rght_pwm2 = 1'b0;
  logic [`RUNNER_APB_AW-1:0] paddr     = '0;
  logic                      psel      = 1'b0;
  logic                      penable   = 1'b0;
  logic                      pwrite    = 1'b0;
  logic [31:0]               pwdata    = '0;
  wire  [31:0]               prdata;
  wire                       pready;
  wire                       pslverr;

  int          data_errs;
  int          bus_errs;
  int          reads;
  int          timeouts  = 0;     // waits that ran out
  logic [31:0] lcg_state = 32'heeab_cd41;
  int          win_cnt   = 0;     // tracks the dut window counter
  int          win_done  = 0;     // windows finished since reset
  int          high_n [4];        // lft1, lft2, rght1, rght2
  int          fixed_n [4];       // used while random is off
  logic        use_rand  = 1'b1;

  always #10 clk = ~clk;  // 20 ns

  runner_physics_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .lft_pwm1  (lft_pwm1),
    .lft_pwm2  (lft_pwm2),
    .rght_pwm1 (rght_pwm1),
    .rght_pwm2 (rght_pwm2),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  runner_physics_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .lft_pwm1  (lft_pwm1),
    .lft_pwm2  (lft_pwm2),
    .rght_pwm1 (rght_pwm1),
    .rght_pwm2 (rght_pwm2),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .data_errs (data_errs),
    .bus_errs  (bus_errs),
    .reads     (reads)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////
  // pwm stimulus
  ////////////////////
  always @(posedge clk) begin : pwm_gen
    int nxt;
    if (!rst_n) begin
      nxt = 0;
      for (int i = 0; i < 4; i++) begin
        high_n[i] = 0;  // first window all low
      end
    end else if (win_cnt == WIN_LEN - 1) begin
      nxt = 0;
      for (int i = 0; i < 4; i++) begin
        lcg_state = lcg_next(lcg_state);
        high_n[i] = use_rand ? int'(lcg_state[31:20]) : fixed_n[i];  // 0..4095
      end
      win_done <= win_done + 1;
    end else begin
      nxt = win_cnt + 1;
    end
    win_cnt   <= nxt;
    lft_pwm1  <= (nxt < high_n[0]);  // high for the first n cycles
    lft_pwm2  <= (nxt < high_n[1]);
    rght_pwm1 <= (nxt < high_n[2]);
    rght_pwm2 <= (nxt < high_n[3]);
  end

  ////////////////////
  // bus and wait helpers
  ////////////////////
  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout: %s did not arrive in time", what);
  endtask

  // stay clear of the window end and its update
  task automatic park_mid_window();
    int t;
    t = 0;
    while ((win_cnt < 256 || win_cnt > WIN_LEN - 512) && t < WIN_LEN) begin
      @(posedge clk);
      t++;
    end
    if (win_cnt < 256 || win_cnt > WIN_LEN - 512) note_timeout("a mid window slot");
  endtask

  task automatic skip_windows(input int n);
    int target;
    int t;
    target = win_done + n;
    t      = 0;
    while (win_done < target && t < n * WIN_LEN + 64) begin
      @(posedge clk);
      t++;
    end
    if (win_done < target) note_timeout("the window end");
  endtask

  task automatic bus_access(input logic [`RUNNER_APB_AW-1:0] addr, input logic wr,
                            input logic [31:0] wdata);
    int t;
    park_mid_window();
    psel    <= 1'b1;  // setup
    penable <= 1'b0;
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;  // access
    @(posedge clk);
    t = 0;
    while (pready !== 1'b1 && t < BUS_WAIT) begin
      @(posedge clk);
      t++;
    end
    if (pready !== 1'b1) note_timeout("pready");
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [`RUNNER_APB_AW-1:0] addr);
    bus_access(addr, 1'b0, 32'h0);
  endtask

  task automatic apb_write(input logic [`RUNNER_APB_AW-1:0] addr, input logic [31:0] data);
    bus_access(addr, 1'b1, data);
  endtask

  task automatic read_all();
    apb_read(CTRL);
    apb_read(OMEGA_LFT);
    apb_read(OMEGA_RGHT);
    apb_read(HEADING);
    apb_read(DUTY_LFT);
    apb_read(DUTY_RGHT);
    apb_read(UPD_CNT);
  endtask

  task automatic run_windows(input int n);
    for (int i = 0; i < n; i++) begin
      skip_windows(1);
      read_all();  // one snapshot per window
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    read_all();                       // reset values
    run_windows(30);                  // random duties

    fixed_n  = '{4095, 0, 0, 4095};   // both wheels full forward
    use_rand = 1'b0;
    run_windows(12);
    fixed_n  = '{0, 4095, 4095, 0};   // full reverse
    run_windows(12);
    use_rand = 1'b1;

    apb_write(CTRL, 32'h0);           // freeze model
    run_windows(3);
    apb_write(CTRL, 32'h1);
    run_windows(3);

    apb_write(CTRL, 32'h3);           // enable plus clear strobe
    read_all();
    run_windows(2);

    apb_read(8'h20);                  // unmapped
    apb_read(8'h1C);
    apb_write(OMEGA_LFT, 32'h1234);   // read only
    apb_write(8'h40, 32'h5);
    apb_read(OMEGA_LFT);
    apb_read(CTRL);

    $display("closing: %0d data errors, %0d bus errors, %0d timeouts, %0d reads checked",
             data_errs, bus_errs, timeouts, reads);
    if (data_errs == 0 && bus_errs == 0 && timeouts == 0 && reads > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
